// File: logic/rv_isa_defines.svh
`ifndef RV_ISA_DEFINES_SVH
`define RV_ISA_DEFINES_SVH

// ##############################
// widths
`define XLEN   32
`define REG_AW 5
`define CSR_AW 12

// ##############################
// instruction field positions
`define OPC_MSB    6
`define OPC_LSB    0
`define RD_MSB     11
`define RD_LSB     7
`define F3_MSB     14
`define F3_LSB     12
`define RS1_MSB    19
`define RS1_LSB    15
`define RS2_MSB    24
`define RS2_LSB    20
`define F7_MSB     31
`define F7_LSB     25
`define IMM_I_MSB  31
`define IMM_I_LSB  20
`define IMM_U_LSB  12

// ##############################
// system encodings
`define FUNCT12_ECALL 12'h000
`define FUNCT12_MRET  12'h302
`define CSR_MEPC      12'h341
`define CSR_MTVEC     12'h305
`define CSR_MCAUSE    12'h342
`define CAUSE_ECALL   32'd11

`endif

// File: logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // the major opcode sits in bits 6:0 of the instruction.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,
        FMT_R    = 3'd1,
        FMT_I    = 3'd2,
        FMT_U    = 3'd3
    } inst_fmt_e;

endpackage

`default_nettype wire

// File: logic/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2
    } csr_op_e;

    typedef enum logic [1:0] {
        SYS_NONE  = 2'd0,
        SYS_ECALL = 2'd1,
        SYS_MRET  = 2'd2
    } sys_op_e;

endpackage

`default_nettype wire

// File: logic/idu.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_isa_defines.svh"

module idu import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_valid,
    input  logic [`XLEN-1:0]   inst,
    input  logic [`XLEN-1:0]   pc,
    output logic               inst_ready,
    input  logic               exu_ready,
    output logic               dec_valid,
    output logic [`REG_AW-1:0] rs1,
    output logic [`REG_AW-1:0] rs2,
    output logic [`REG_AW-1:0] rd,
    output logic               reg_we,
    output logic               use_imm,
    output logic [`XLEN-1:0]   imm,
    output logic [`XLEN-1:0]   pc_q,
    output alu_op_e            alu_op,
    output csr_op_e            csr_op,
    output sys_op_e            sys_op,
    output logic [`CSR_AW-1:0] csr_addr
);

    logic [`XLEN-1:0] inst_q;
    logic             accept;
    logic             exu_fire;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    opcode_e          opcode;
    inst_fmt_e        fmt;

    assign accept   = inst_valid && inst_ready;
    assign exu_fire = dec_valid && exu_ready;

    // ##############################
    // one-entry handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_ready <= 1'b1;
        end else if (accept) begin
            inst_ready <= 1'b0;
        end else if (exu_fire) begin
            inst_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (exu_fire) begin
            dec_valid <= 1'b0;
        end else if (accept) begin
            dec_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q <= inst;
            pc_q   <= pc;
        end
    end

    // ##############################
    // field extraction
    assign opcode   = opcode_e'(inst_q[`OPC_MSB:`OPC_LSB]);
    assign funct3   = inst_q[`F3_MSB:`F3_LSB];
    assign funct7   = inst_q[`F7_MSB:`F7_LSB];
    assign rs1      = inst_q[`RS1_MSB:`RS1_LSB];
    assign rs2      = inst_q[`RS2_MSB:`RS2_LSB];
    assign rd       = inst_q[`RD_MSB:`RD_LSB];
    assign csr_addr = inst_q[`IMM_I_MSB:`IMM_I_LSB];

    always_comb begin
        alu_op  = ALU_PASS_B;
        csr_op  = CSR_NONE;
        sys_op  = SYS_NONE;
        reg_we  = 1'b0;
        use_imm = 1'b1; // with no format the immediate is zero, so PASS_B yields zero.
        fmt     = FMT_NONE;
        case (opcode)
            OPC_OP: begin
                fmt     = FMT_R;
                reg_we  = 1'b1;
                use_imm = 1'b0;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op = ALU_ADD;
                    {7'h20, 3'b000}: alu_op = ALU_SUB;
                    {7'h00, 3'b111}: alu_op = ALU_AND;
                    {7'h00, 3'b110}: alu_op = ALU_OR;
                    {7'h00, 3'b100}: alu_op = ALU_XOR;
                    {7'h00, 3'b010}: alu_op = ALU_SLT;
                    default: begin
                        reg_we  = 1'b0;
                        use_imm = 1'b1;
                    end
                endcase
            end
            OPC_OP_IMM: begin
                fmt    = FMT_I;
                reg_we = 1'b1;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b111:  alu_op = ALU_AND;
                    3'b110:  alu_op = ALU_OR;
                    3'b100:  alu_op = ALU_XOR;
                    default: reg_we = 1'b0;
                endcase
            end
            OPC_LUI: begin
                fmt    = FMT_U;
                reg_we = 1'b1;
            end
            OPC_SYSTEM: begin
                case (funct3)
                    3'b001: begin
                        csr_op = CSR_WRITE;
                        reg_we = 1'b1;
                    end
                    3'b010: begin
                        csr_op = CSR_SET;
                        reg_we = 1'b1;
                    end
                    3'b000: begin
                        if (csr_addr == `FUNCT12_ECALL) begin
                            sys_op = SYS_ECALL;
                        end else if (csr_addr == `FUNCT12_MRET) begin
                            sys_op = SYS_MRET;
                        end
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I:   imm = {{(`XLEN-12){inst_q[`IMM_I_MSB]}}, inst_q[`IMM_I_MSB:`IMM_I_LSB]};
            FMT_U:   imm = {inst_q[`XLEN-1:`IMM_U_LSB], {`IMM_U_LSB{1'b0}}};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/gpr_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_isa_defines.svh"

module gpr_file (
    input  logic               clk,
    input  logic               rst,
    input  logic [`REG_AW-1:0] rs1,
    input  logic [`REG_AW-1:0] rs2,
    output logic [`XLEN-1:0]   src1,
    output logic [`XLEN-1:0]   src2,
    input  logic               gpr_we,
    input  logic [`REG_AW-1:0] gpr_waddr,
    input  logic [`XLEN-1:0]   gpr_wdata
);

    logic [`XLEN-1:0] regs [0:(1<<`REG_AW)-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_we && (gpr_waddr != '0)) begin
            regs[gpr_waddr] <= gpr_wdata; // x0 is never written, so it stays zero.
        end
    end

    assign src1 = regs[rs1];
    assign src2 = regs[rs2];

endmodule

`default_nettype wire

// File: logic/csr_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_isa_defines.svh"

module csr_file import rv_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [`CSR_AW-1:0] csr_addr,
    output logic [`XLEN-1:0]   csr_rdata,
    input  logic               csr_we,
    input  csr_op_e            csr_op,
    input  logic [`XLEN-1:0]   csr_src,
    input  logic               trap_en,
    input  logic [`XLEN-1:0]   trap_pc,
    output logic [`XLEN-1:0]   mepc,
    output logic [`XLEN-1:0]   mtvec
);

    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] wdata;

    always_comb begin
        case (csr_addr)
            `CSR_MEPC:   csr_rdata = mepc;
            `CSR_MTVEC:  csr_rdata = mtvec;
            `CSR_MCAUSE: csr_rdata = mcause;
            default:     csr_rdata = '0; // unknown addresses read as zero.
        endcase
    end

    assign wdata = (csr_op == CSR_SET) ? (csr_rdata | csr_src) : csr_src;

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc   <= '0;
            mtvec  <= '0;
            mcause <= '0;
        end else if (trap_en) begin
            mepc   <= trap_pc;
            mcause <= `CAUSE_ECALL;
        end else if (csr_we) begin
            case (csr_addr)
                `CSR_MEPC:   mepc   <= wdata;
                `CSR_MTVEC:  mtvec  <= wdata;
                `CSR_MCAUSE: mcause <= wdata;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/exu.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_isa_defines.svh"

module exu import rv_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               dec_valid,
    output logic               exu_ready,
    input  alu_op_e            alu_op,
    input  csr_op_e            csr_op,
    input  sys_op_e            sys_op,
    input  logic [`REG_AW-1:0] rd,
    input  logic               reg_we,
    input  logic               use_imm,
    input  logic [`XLEN-1:0]   imm,
    input  logic [`XLEN-1:0]   pc_q,
    input  logic [`XLEN-1:0]   src1,
    input  logic [`XLEN-1:0]   src2,
    input  logic [`XLEN-1:0]   csr_rdata,
    input  logic [`XLEN-1:0]   mepc,
    input  logic [`XLEN-1:0]   mtvec,
    output logic               gpr_we,
    output logic               csr_we,
    output logic               trap_en,
    output logic [`REG_AW-1:0] gpr_waddr,
    output logic [`XLEN-1:0]   gpr_wdata,
    output logic               wb_valid,
    input  logic               wb_ready,
    output logic [`REG_AW-1:0] wb_rd,
    output logic               wb_we,
    output logic               wb_redirect,
    output logic [`XLEN-1:0]   wb_data,
    output logic [`XLEN-1:0]   wb_next_pc
);

    logic             exu_fire;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] next_pc;

    assign exu_ready = !wb_valid || wb_ready; // free, or being drained this cycle.
    assign exu_fire  = dec_valid && exu_ready;
    assign op_b      = use_imm ? imm : src2;

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_out = src1 + op_b;
            ALU_SUB: alu_out = src1 - op_b;
            ALU_AND: alu_out = src1 & op_b;
            ALU_OR:  alu_out = src1 | op_b;
            ALU_XOR: alu_out = src1 ^ op_b;
            ALU_SLT: alu_out = {{(`XLEN-1){1'b0}}, $signed(src1) < $signed(op_b)};
            default: alu_out = op_b;
        endcase
    end

    assign result = (csr_op != CSR_NONE) ? csr_rdata : alu_out; // csr ops return the old value.

    always_comb begin
        case (sys_op)
            SYS_ECALL: next_pc = mtvec;
            SYS_MRET:  next_pc = mepc;
            default:   next_pc = pc_q + `XLEN'd4;
        endcase
    end

    assign gpr_we    = exu_fire && reg_we;
    assign gpr_waddr = rd;
    assign gpr_wdata = result;
    assign csr_we    = exu_fire && (csr_op != CSR_NONE);
    assign trap_en   = exu_fire && (sys_op == SYS_ECALL);

    // ##############################
    // writeback result register
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (exu_fire) begin
            wb_valid <= 1'b1;
        end else if (wb_ready) begin
            wb_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (exu_fire) begin
            wb_rd       <= rd;
            wb_we       <= reg_we;
            wb_data     <= result;
            wb_redirect <= (sys_op != SYS_NONE);
            wb_next_pc  <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: logic/core_slice_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_isa_defines.svh"

module core_slice_top import rv_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_valid,
    output logic               inst_ready,
    input  logic [`XLEN-1:0]   inst,
    input  logic [`XLEN-1:0]   pc,
    output logic               wb_valid,
    input  logic               wb_ready,
    output logic [`REG_AW-1:0] wb_rd,
    output logic               wb_we,
    output logic [`XLEN-1:0]   wb_data,
    output logic               wb_redirect,
    output logic [`XLEN-1:0]   wb_next_pc
);

    // decode to execute.
    logic               dec_valid;
    logic               exu_ready;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    logic               reg_we;
    logic               use_imm;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   pc_q;
    alu_op_e            alu_op;
    csr_op_e            csr_op;
    sys_op_e            sys_op;
    logic [`CSR_AW-1:0] csr_addr;
    logic [`XLEN-1:0]   src1;
    logic [`XLEN-1:0]   src2;

    // register file and csr traffic.
    logic               gpr_we;
    logic [`REG_AW-1:0] gpr_waddr;
    logic [`XLEN-1:0]   gpr_wdata;
    logic               csr_we;
    logic               trap_en;
    logic [`XLEN-1:0]   csr_rdata;
    logic [`XLEN-1:0]   mepc;
    logic [`XLEN-1:0]   mtvec;

    idu u_idu (.*);

    gpr_file u_gpr_file (.*);

    csr_file u_csr_file (
        .*,
        .csr_src (src1), // the csr source operand is rs1.
        .trap_pc (pc_q)
    );

    exu u_exu (.*);

endmodule

`default_nettype wire

// File: tests/core_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_isa_defines.svh"

module core_checker import rv_isa_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_valid,
    input  logic               inst_ready,
    input  logic [`XLEN-1:0]   inst,
    input  logic [`XLEN-1:0]   pc,
    input  logic               wb_valid,
    input  logic               wb_ready,
    input  logic [`REG_AW-1:0] wb_rd,
    input  logic               wb_we,
    input  logic [`XLEN-1:0]   wb_data,
    input  logic               wb_redirect,
    input  logic [`XLEN-1:0]   wb_next_pc,
    input  logic               latency_check,
    input  logic               test_end,
    input  int                 test_id,
    output int                 error_count,
    output int                 check_count,
    output int                 pending,
    output int                 tests_failed
);

    logic [`XLEN-1:0] inst_q [$];
    logic [`XLEN-1:0] pc_q [$];
    int               cycle_q [$];
    logic [`XLEN-1:0] regs [0:31];
    logic [`XLEN-1:0] m_mepc;
    logic [`XLEN-1:0] m_mtvec;
    logic [`XLEN-1:0] m_mcause;
    int               cycle;
    int               latency;
    int               test_checks;
    int               test_errors;

    function automatic string test_name(input int id);
        case (id)
            0:       return "alu";
            1:       return "lui";
            2:       return "csr";
            3:       return "trap";
            4:       return "back_pressure";
            5:       return "latency";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] csr_value(input logic [`CSR_AW-1:0] addr);
        case (addr)
            `CSR_MEPC:   return m_mepc;
            `CSR_MTVEC:  return m_mtvec;
            `CSR_MCAUSE: return m_mcause;
            default:     return '0;
        endcase
    endfunction

    task automatic csr_update(input logic [`CSR_AW-1:0] addr, input logic [`XLEN-1:0] value);
        case (addr)
            `CSR_MEPC:   m_mepc = value;
            `CSR_MTVEC:  m_mtvec = value;
            `CSR_MCAUSE: m_mcause = value;
            default: ;
        endcase
    endtask

    task automatic flag_error();
        error_count++;
        test_errors++;
    endtask

    task automatic compare(input string name, input logic [`XLEN-1:0] expected,
                           input logic [`XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected 0x%08h, actual 0x%08h",
                     $time, name, expected, actual);
            flag_error();
        end
    endtask

    // ##############################
    // reference model applied in program order at each writeback
    task automatic check_writeback(input logic [`XLEN-1:0] word, input logic [`XLEN-1:0] ipc);
        logic [`REG_AW-1:0] rd_i;
        logic [`CSR_AW-1:0] f12;
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
        logic [`XLEN-1:0]   imm_i;
        logic [`XLEN-1:0]   old;
        logic [`XLEN-1:0]   exp_data;
        logic [`XLEN-1:0]   exp_pc;
        logic               exp_we;
        logic               exp_redir;
        rd_i      = word[11:7];
        f12       = word[31:20];
        a         = regs[word[19:15]];
        b         = regs[word[24:20]];
        imm_i     = {{20{word[31]}}, word[31:20]};
        exp_we    = 1'b0;
        exp_redir = 1'b0;
        exp_data  = '0;
        exp_pc    = ipc + 32'd4;
        case (word[6:0])
            OPC_OP: begin
                exp_we = 1'b1;
                case ({word[31:25], word[14:12]})
                    10'b0000000_000: exp_data = a + b;
                    10'b0100000_000: exp_data = a - b;
                    10'b0000000_111: exp_data = a & b;
                    10'b0000000_110: exp_data = a | b;
                    10'b0000000_100: exp_data = a ^ b;
                    10'b0000000_010: exp_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:         exp_we = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                exp_we = 1'b1;
                case (word[14:12])
                    3'b000:  exp_data = a + imm_i;
                    3'b111:  exp_data = a & imm_i;
                    3'b110:  exp_data = a | imm_i;
                    3'b100:  exp_data = a ^ imm_i;
                    default: exp_we = 1'b0;
                endcase
            end
            OPC_LUI: begin
                exp_we   = 1'b1;
                exp_data = {word[31:12], 12'h000};
            end
            OPC_SYSTEM: begin
                if (word[14:12] == 3'b001 || word[14:12] == 3'b010) begin
                    old      = csr_value(f12); // the old value goes to rd.
                    exp_we   = 1'b1;
                    exp_data = old;
                    csr_update(f12, (word[14:12] == 3'b001) ? a : (old | a));
                end else if (f12 == `FUNCT12_ECALL) begin
                    exp_redir = 1'b1;
                    exp_pc    = m_mtvec;
                    m_mepc    = ipc;
                    m_mcause  = `CAUSE_ECALL;
                end else begin
                    exp_redir = 1'b1;
                    exp_pc    = m_mepc;
                end
            end
            default: ;
        endcase
        if (exp_we && rd_i != 5'd0) begin
            regs[rd_i] = exp_data; // x0 keeps reading zero.
        end
        compare("wb_rd", `XLEN'(rd_i), `XLEN'(wb_rd));
        compare("wb_we", `XLEN'(exp_we), `XLEN'(wb_we));
        if (exp_we) begin
            compare("wb_data", exp_data, wb_data);
        end
        compare("wb_redirect", `XLEN'(exp_redir), `XLEN'(wb_redirect));
        compare("wb_next_pc", exp_pc, wb_next_pc);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            m_mepc   = '0;
            m_mtvec  = '0;
            m_mcause = '0;
            inst_q.delete();
            pc_q.delete();
            cycle_q.delete();
            cycle        = 0;
            error_count  = 0;
            check_count  = 0;
            pending      = 0;
            tests_failed = 0;
            test_checks  = 0;
            test_errors  = 0;
        end else begin
            if (inst_ready && pending >= 2) begin
                $display("Error at %0t: inst_ready is high while two instructions are held.",
                         $time);
                flag_error();
            end
            if (wb_valid && wb_ready) begin
                if (inst_q.size() == 0) begin
                    $display("Error at %0t: a writeback came with no instruction outstanding.",
                             $time);
                    flag_error();
                end else begin
                    latency = cycle - cycle_q.pop_front();
                    if (latency_check && latency != 2) begin
                        $display("Error at %0t: writeback came %0d cycles after accept, not 2.",
                                 $time, latency);
                        flag_error();
                    end
                    check_writeback(inst_q.pop_front(), pc_q.pop_front());
                    check_count++;
                    test_checks++;
                end
            end
            if (inst_valid && inst_ready) begin
                inst_q.push_back(inst);
                pc_q.push_back(pc);
                cycle_q.push_back(cycle);
            end
            pending = inst_q.size();
            if (test_end) begin
                $display("test %s finished: %0d writebacks checked, %0d errors",
                         test_name(test_id), test_checks, test_errors);
                if (test_errors != 0) begin
                    tests_failed++;
                end
                test_checks = 0;
                test_errors = 0;
            end
            cycle++;
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_core_slice.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_isa_defines.svh"

module tb_core_slice import rv_isa_pkg::*, rv_ctrl_pkg::*; ();

    localparam int N_ALU       = 200;
    localparam int N_LUI       = 40;
    localparam int N_CSR       = 80;
    localparam int N_TRAP      = 60; // ten rounds of six instructions.
    localparam int N_BP        = 200;
    localparam int N_LAT       = 60;
    localparam int N_TESTS     = 6;
    localparam int TOTAL_INSTS = N_ALU + N_LUI + N_CSR + N_TRAP + N_BP + N_LAT;

    logic               clk = 1'b0;
    logic               rst;
    logic               inst_valid;
    logic               inst_ready;
    logic [`XLEN-1:0]   inst;
    logic [`XLEN-1:0]   pc;
    logic               wb_valid;
    logic               wb_ready = 1'b1;
    logic [`REG_AW-1:0] wb_rd;
    logic               wb_we;
    logic [`XLEN-1:0]   wb_data;
    logic               wb_redirect;
    logic [`XLEN-1:0]   wb_next_pc;
    logic               latency_check = 1'b0;
    logic               test_end;
    int                 test_id;
    int                 error_count;
    int                 check_count;
    int                 pending;
    int                 tests_failed;
    bit                 gaps_on = 1'b0;
    bit                 bp_on = 1'b0;

    always #4 clk = ~clk;

    core_slice_top u_core_slice_top (.*);

    core_checker u_core_checker (.*);

    always @(negedge clk) begin
        wb_ready <= bp_on ? ($urandom_range(0, 2) != 0) : 1'b1;
    end

    // ##############################
    // instruction encoders
    function automatic logic [`XLEN-1:0] build_r_type(input logic [6:0] funct7,
            input logic [2:0] funct3, input logic [4:0] rd, input logic [4:0] rs1,
            input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, OPC_OP};
    endfunction

    function automatic logic [`XLEN-1:0] build_i_type(input logic [2:0] funct3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm12);
        return {imm12, rs1, funct3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [`XLEN-1:0] build_u_type(input logic [4:0] rd,
            input logic [19:0] imm20);
        return {imm20, rd, OPC_LUI};
    endfunction

    function automatic logic [`XLEN-1:0] build_system(input logic [11:0] funct12,
            input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
        return {funct12, rs1, funct3, rd, OPC_SYSTEM};
    endfunction

    function automatic logic [`REG_AW-1:0] rand_reg();
        return `REG_AW'($urandom_range(0, 7)); // a small set, so results are read back often.
    endfunction

    function automatic logic [`XLEN-1:0] random_alu_inst();
        logic [11:0] imm12;
        int          sel;
        imm12 = 12'($urandom());
        sel   = $urandom_range(0, 9);
        case (sel)
            0:       return build_r_type(7'h00, 3'b000, rand_reg(), rand_reg(), rand_reg());
            1:       return build_r_type(7'h20, 3'b000, rand_reg(), rand_reg(), rand_reg());
            2:       return build_r_type(7'h00, 3'b111, rand_reg(), rand_reg(), rand_reg());
            3:       return build_r_type(7'h00, 3'b110, rand_reg(), rand_reg(), rand_reg());
            4:       return build_r_type(7'h00, 3'b100, rand_reg(), rand_reg(), rand_reg());
            5:       return build_r_type(7'h00, 3'b010, rand_reg(), rand_reg(), rand_reg());
            6:       return build_i_type(3'b000, rand_reg(), rand_reg(), imm12);
            7:       return build_i_type(3'b111, rand_reg(), rand_reg(), imm12);
            8:       return build_i_type(3'b110, rand_reg(), rand_reg(), imm12);
            default: return build_i_type(3'b100, rand_reg(), rand_reg(), imm12);
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] random_lui_inst();
        return build_u_type(rand_reg(), 20'($urandom()));
    endfunction

    function automatic logic [`CSR_AW-1:0] random_csr_addr();
        case ($urandom_range(0, 3))
            0:       return `CSR_MEPC;
            1:       return `CSR_MTVEC;
            2:       return `CSR_MCAUSE;
            default: return 12'h340; // mscratch is not present in this slice.
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] random_csr_inst();
        return build_system(random_csr_addr(), rand_reg(),
                            ($urandom_range(0, 1) == 0) ? 3'b001 : 3'b010, rand_reg());
    endfunction

    // set mtvec, trap, read mepc and mcause back, then return.
    function automatic logic [`XLEN-1:0] trap_step(input int step);
        case (step)
            0:       return build_u_type(5'd5, 20'($urandom()));
            1:       return build_system(`CSR_MTVEC, 5'd5, 3'b001, rand_reg());
            2:       return build_system(`FUNCT12_ECALL, 5'd0, 3'b000, 5'd0);
            3:       return build_system(`CSR_MEPC, 5'd0, 3'b010, rand_reg());
            4:       return build_system(`CSR_MCAUSE, 5'd0, 3'b010, rand_reg());
            default: return build_system(`FUNCT12_MRET, 5'd0, 3'b000, 5'd0);
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] random_any_inst();
        int sel;
        sel = $urandom_range(0, 9);
        case (sel)
            5:       return random_lui_inst();
            6, 7:    return random_csr_inst();
            8:       return build_system(`FUNCT12_ECALL, 5'd0, 3'b000, 5'd0);
            9:       return build_system(`FUNCT12_MRET, 5'd0, 3'b000, 5'd0);
            default: return random_alu_inst();
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] next_inst(input int id, input int n);
        case (id)
            0:       return random_alu_inst();
            1:       return (n % 4 == 3) ? random_alu_inst() : random_lui_inst();
            2:       return (n % 4 == 3) ? random_lui_inst() : random_csr_inst();
            3:       return trap_step(n % 6);
            default: return random_any_inst();
        endcase
    endfunction

    // ##############################
    // stimulus
    task automatic send_inst(input logic [`XLEN-1:0] word);
        logic [`XLEN-1:0] r;
        logic             taken;
        r          = $urandom();
        inst       = word;
        pc         = {r[`XLEN-1:2], 2'b00};
        inst_valid = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            taken = inst_ready; // registered, so it holds through the next rising edge.
            @(negedge clk);
        end
        inst_valid = 1'b0;
        if (gaps_on) begin
            repeat ($urandom_range(0, 2)) @(negedge clk);
        end
    endtask

    task automatic set_modes(input bit gaps, input bit bp, input bit lat);
        @(posedge clk);
        bp_on = bp;
        @(negedge clk);
        gaps_on       = gaps;
        latency_check = lat;
    endtask

    task automatic run_test(input int id, input int count, input bit gaps, input bit bp,
                            input bit lat);
        set_modes(gaps, bp, lat);
        test_id = id;
        for (int n = 0; n < count; n++) begin
            send_inst(next_inst(id, n));
        end
        while (pending != 0) begin
            @(negedge clk);
        end
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    initial begin
        void'($urandom(84));
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        test_end   = 1'b0;
        test_id    = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        run_test(0, N_ALU, 1'b1, 1'b0, 1'b0);
        run_test(1, N_LUI, 1'b1, 1'b0, 1'b0);
        run_test(2, N_CSR, 1'b1, 1'b0, 1'b0);
        run_test(3, N_TRAP, 1'b1, 1'b0, 1'b0);
        run_test(4, N_BP, 1'b1, 1'b1, 1'b0);
        run_test(5, N_LAT, 1'b0, 1'b0, 1'b1);
        @(negedge clk);
        $display("summary: %0d tests, %0d failed, %0d writebacks checked, %0d errors",
                 N_TESTS, tests_failed, check_count, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // about 40 cycles per instruction covers gaps and stalls with a wide margin.
    initial begin
        repeat (40 * TOTAL_INSTS) @(posedge clk);
        $display("Error: the watchdog expired after %0d cycles before the tests finished.",
                 40 * TOTAL_INSTS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/rv_ctrl_pkg.sv
logic/idu.sv
logic/gpr_file.sv
logic/csr_file.sv
logic/exu.sv
logic/core_slice_top.sv
tests/core_checker.sv
tests/tb_core_slice.sv

// File: Makefile
TOP := tb_core_slice

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "Result: PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
